// File: files.f
verilog/rv_pkg.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_imm_gen.sv
verilog/rv_memory.sv
verilog/rv_control.sv
verilog/rv_core_top.sv
tests/tb_rv_core.sv

// File: Makefile
# Verilator build for the rv32i multicycle core

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$($(BUILD_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        prog_we;
    logic [7:0]  prog_addr;
    logic [31:0] prog_data;
    logic        retire;
    logic [31:0] retire_pc;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        store_we;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic        trap;

    // program image, shared by the loader and the model
    logic [31:0] prog [256];
    int          prog_len;

    // reference model state
    logic [31:0] m_pc;
    logic [31:0] m_regs [32];
    logic [31:0] m_dmem [256];
    logic [31:0] lcg_state;

    // expected values for the current retire
    logic [31:0] exp_pc;
    logic        exp_wb_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_wb;
    logic        exp_st_we;
    logic [31:0] exp_st_addr;
    logic [31:0] exp_st_data;
    logic [31:0] exp_gap;
    logic        exp_legal;

    // monitor bookkeeping
    logic        mon_en;
    logic        halted;
    logic [31:0] halt_pc;
    logic [31:0] cycle_cnt;
    logic [31:0] last_retire;

    rv_core_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .retire     (retire),
        .retire_pc  (retire_pc),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .store_we   (store_we),
        .store_addr (store_addr),
        .store_data (store_data),
        .trap       (trap)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    // lcg, numerical recipes constants
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [11:0] rand_imm12();
        logic [31:0] r;
        r = next_rand();
        return r[23:12];
    endfunction

    function automatic logic [19:0] rand_imm20();
        logic [31:0] r;
        r = next_rand();
        return r[31:12];
    endfunction

    // rv32i encoders
    function automatic logic [31:0] rop_instr(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // f3 000 beq, 001 bne
    function automatic logic [31:0] branch_instr(input logic [2:0] f3, input logic [4:0] rs1,
                                                 input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_instr(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [31:0] auipc_instr(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0010111};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len = prog_len + 1;
    endtask

    // one retire of the reference model, straight from the isa rules
    task automatic model_retire();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] nxt;
        logic [31:0] addr;
        ins   = prog[m_pc[9:2]];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        res   = 32'd0;
        nxt   = m_pc + 32'd4;
        exp_pc    = m_pc;
        exp_rd    = ins[11:7];
        exp_wb_we = 1'b0;
        exp_st_we = 1'b0;
        exp_gap   = 32'd3;
        exp_legal = 1'b1;
        case (ins[6:0])
            7'b0110011: begin
                exp_wb_we = 1'b1;
                case (ins[14:12])
                    3'b000:  res = ins[30] ? a - b : a + b;
                    3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    3'b111:  res = a & b;
                    default: res = 32'd0;
                endcase
            end
            7'b0010011: begin
                exp_wb_we = 1'b1;
                res = a + imm_i;
            end
            7'b0000011: begin
                // loads spend one more cycle
                addr      = a + imm_i;
                exp_wb_we = 1'b1;
                exp_gap   = 32'd4;
                res       = m_dmem[addr[9:2]];
            end
            7'b0100011: begin
                addr        = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                exp_st_we   = 1'b1;
                exp_st_addr = addr;
                exp_st_data = b;
                m_dmem[addr[9:2]] = b;
            end
            7'b1100011: begin
                if ((ins[14:12] == 3'b000) ? (a == b) : (a != b)) begin
                    nxt = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                exp_wb_we = 1'b1;
                res = m_pc + 32'd4;
                nxt = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                // target from the old rs1, low bit dropped
                exp_wb_we = 1'b1;
                res = m_pc + 32'd4;
                nxt = (a + imm_i) & ~32'd1;
            end
            7'b0010111: begin
                exp_wb_we = 1'b1;
                res = m_pc + {ins[31:12], 12'd0};
            end
            default: exp_legal = 1'b0;
        endcase
        exp_wb = (exp_rd == 5'd0) ? 32'd0 : res;
        if (exp_wb_we && exp_rd != 5'd0) begin
            m_regs[exp_rd] = res;
        end
        m_pc = nxt;
    endtask

    // compares every strobe at the falling edge, outputs settled by then
    always @(negedge clk) begin
        if (mon_en) begin
            cycle_cnt = cycle_cnt + 32'd1;
            if (retire === 1'b1) begin
                model_retire();
                assert (exp_legal) else begin
                    $display("retire seen for an unsupported opcode at pc %h", exp_pc);
                    stop_on_failure();
                end
                check_value("retire_pc", exp_pc, retire_pc);
                check_value("retire_gap", exp_gap, cycle_cnt - last_retire);
                last_retire = cycle_cnt;
                check_value("wb_we", 32'(exp_wb_we), 32'(wb_we));
                if (exp_wb_we) begin
                    check_value("wb_rd", 32'(exp_rd), 32'(wb_rd));
                    check_value("wb_data", exp_wb, wb_data);
                end
                check_value("store_we", 32'(exp_st_we), 32'(store_we));
                if (exp_st_we) begin
                    check_value("store_addr", exp_st_addr, store_addr);
                    check_value("store_data", exp_st_data, store_data);
                end
                check_value("trap", 32'd0, 32'(trap));
                if (exp_pc == halt_pc) begin
                    halted = 1'b1;
                end
            end else begin
                check_value("wb_we", 32'd0, 32'(wb_we));
                check_value("store_we", 32'd0, 32'(store_we));
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        mon_en = 1'b0;
        run   <= 1'b0;
        rst_n <= 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b0;
        m_pc        = 32'd0;
        halted      = 1'b0;
        cycle_cnt   = 32'd0;
        last_retire = 32'd0;
        prog_len    = 0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'd0;
        end
        @(negedge clk);
        check_value("retire", 32'd0, 32'(retire));
        check_value("wb_we", 32'd0, 32'(wb_we));
        check_value("store_we", 32'd0, 32'(store_we));
        check_value("trap", 32'd0, 32'(trap));
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 8'(i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        // read port catches up with the last write
        repeat (2) @(posedge clk);
    endtask

    task automatic wait_halt(input int limit);
        int n;
        n = 0;
        while (!halted && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (halted) else begin
            $display("timeout: no retire at pc %h within %0d cycles", halt_pc, limit);
            stop_on_failure();
        end
    endtask

    task automatic wait_trap(input int limit);
        int n;
        n = 0;
        while (trap !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (trap === 1'b1) else begin
            $display("timeout: trap not raised within %0d cycles", limit);
            stop_on_failure();
        end
    endtask

    task automatic start_program();
        load_program();
        @(posedge clk);
        run <= 1'b1;
        mon_en = 1'b1;
    endtask

    // last word of every program is a jump to itself
    task automatic run_program();
        halt_pc = 32'(4 * (prog_len - 1));
        start_program();
        wait_halt(2000);
        @(posedge clk);
        run <= 1'b0;
        mon_en = 1'b0;
    endtask

    task automatic alu_program_test();
        apply_reset();
        for (int i = 1; i <= 6; i++) begin
            emit(addi_instr(5'(i), 5'd0, rand_imm12()));
        end
        // large operands from auipc at pc 24 and 28
        emit(auipc_instr(5'd7, 20'h7ffff));
        emit(auipc_instr(5'd9, 20'h80000));
        emit(rop_instr(7'h00, 3'b000, 5'd10, 5'd7, 5'd7));
        emit(rop_instr(7'h20, 3'b000, 5'd11, 5'd9, 5'd7));
        emit(rop_instr(7'h00, 3'b010, 5'd12, 5'd9, 5'd7));
        emit(rop_instr(7'h00, 3'b010, 5'd13, 5'd7, 5'd9));
        // random operands through each op
        emit(rop_instr(7'h00, 3'b000, 5'd14, 5'd1, 5'd2));
        emit(rop_instr(7'h20, 3'b000, 5'd15, 5'd3, 5'd4));
        emit(rop_instr(7'h00, 3'b111, 5'd16, 5'd5, 5'd6));
        emit(rop_instr(7'h00, 3'b110, 5'd17, 5'd1, 5'd6));
        emit(rop_instr(7'h00, 3'b100, 5'd18, 5'd2, 5'd5));
        emit(rop_instr(7'h00, 3'b010, 5'd19, 5'd3, 5'd4));
        emit(rop_instr(7'h00, 3'b010, 5'd20, 5'd4, 5'd3));
        // x0 writes, then read x0 back
        emit(addi_instr(5'd0, 5'd1, 12'd5));
        emit(rop_instr(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
        emit(rop_instr(7'h00, 3'b000, 5'd21, 5'd0, 5'd1));
        emit(jal_instr(5'd0, 21'd0));
        run_program();
    endtask

    task automatic memory_program_test();
        apply_reset();
        emit(addi_instr(5'd1, 5'd0, 12'h200));
        for (int i = 0; i < 4; i++) begin
            emit(auipc_instr(5'd2, rand_imm20()));
            emit(addi_instr(5'd2, 5'd2, rand_imm12()));
            emit(sw_instr(5'd2, 5'd1, 12'(4 * i - 8)));
        end
        for (int i = 0; i < 4; i++) begin
            emit(lw_instr(5'(10 + i), 5'd1, 12'(4 * i - 8)));
        end
        // overwrite a word and read it back
        emit(sw_instr(5'd10, 5'd1, 12'h004));
        emit(lw_instr(5'd20, 5'd1, 12'h004));
        emit(jal_instr(5'd0, 21'd0));
        run_program();
    endtask

    task automatic branch_program_test();
        apply_reset();
        emit(addi_instr(5'd1, 5'd0, 12'd5));
        emit(addi_instr(5'd2, 5'd0, 12'd5));
        emit(addi_instr(5'd3, 5'd0, 12'd7));
        emit(branch_instr(3'b000, 5'd1, 5'd2, 13'd8));
        emit(addi_instr(5'd4, 5'd0, 12'd1));
        emit(branch_instr(3'b001, 5'd1, 5'd3, 13'd8));
        emit(addi_instr(5'd4, 5'd0, 12'd2));
        // both not taken
        emit(branch_instr(3'b000, 5'd1, 5'd3, 13'd8));
        emit(branch_instr(3'b001, 5'd1, 5'd2, 13'd8));
        emit(addi_instr(5'd5, 5'd0, 12'd3));
        // backward loop, seven passes
        emit(addi_instr(5'd6, 5'd6, 12'd1));
        emit(branch_instr(3'b001, 5'd6, 5'd3, 13'h1ffc));
        emit(addi_instr(5'd7, 5'd0, rand_imm12()));
        emit(addi_instr(5'd8, 5'd0, rand_imm12()));
        emit(branch_instr(3'b000, 5'd7, 5'd8, 13'd8));
        emit(addi_instr(5'd9, 5'd0, 12'd1));
        emit(branch_instr(3'b001, 5'd7, 5'd8, 13'd8));
        emit(addi_instr(5'd9, 5'd0, 12'd2));
        emit(jal_instr(5'd0, 21'd0));
        run_program();
    endtask

    task automatic jump_program_test();
        apply_reset();
        emit(auipc_instr(5'd1, 20'h12345));
        emit(jal_instr(5'd2, 21'd12));
        emit(addi_instr(5'd3, 5'd0, 12'd1));
        emit(addi_instr(5'd3, 5'd0, 12'd2));
        // odd target, lands on 36
        emit(addi_instr(5'd4, 5'd0, 12'd37));
        emit(jalr_instr(5'd5, 5'd4, 12'd0));
        emit(addi_instr(5'd3, 5'd0, 12'd3));
        emit(addi_instr(5'd3, 5'd0, 12'd4));
        emit(addi_instr(5'd3, 5'd0, 12'd5));
        emit(auipc_instr(5'd6, 20'd0));
        // rd equals rs1, lands on 48
        emit(jalr_instr(5'd6, 5'd6, 12'd13));
        emit(addi_instr(5'd3, 5'd0, 12'd6));
        emit(jal_instr(5'd8, 21'd12));
        emit(jal_instr(5'd0, 21'd16));
        emit(addi_instr(5'd3, 5'd0, 12'd7));
        emit(jal_instr(5'd9, 21'h1ffff8));
        emit(addi_instr(5'd3, 5'd0, 12'd8));
        emit(jal_instr(5'd0, 21'd0));
        run_program();
    endtask

    task automatic timing_trap_test();
        apply_reset();
        emit(addi_instr(5'd1, 5'd0, 12'h300));
        emit(addi_instr(5'd2, 5'd0, rand_imm12()));
        emit(sw_instr(5'd2, 5'd1, 12'd0));
        emit(lw_instr(5'd3, 5'd1, 12'd0));
        emit(rop_instr(7'h00, 3'b000, 5'd4, 5'd3, 5'd2));
        emit(lw_instr(5'd5, 5'd1, 12'd0));
        emit(branch_instr(3'b000, 5'd0, 5'd0, 13'd8));
        emit(addi_instr(5'd6, 5'd0, 12'd1));
        // back-to-back loads
        emit(lw_instr(5'd7, 5'd1, 12'd0));
        emit(lw_instr(5'd8, 5'd1, 12'd0));
        // lui is outside the subset, traps at pc 40
        emit({20'h12345, 5'd9, 7'b0110111});
        emit(jal_instr(5'd0, 21'd0));
        halt_pc = 32'hffff_fffc;
        start_program();
        wait_trap(500);
        check_value("model next pc at trap", 32'd40, m_pc);
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            check_value("retire", 32'd0, 32'(retire));
            check_value("trap", 32'd1, 32'(trap));
        end
        // apply_reset also checks that trap clears
        apply_reset();
    endtask

    initial begin
        rst_n     = 1'b1;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = 8'd0;
        prog_data = 32'd0;
        mon_en    = 1'b0;
        halted    = 1'b0;
        halt_pc   = 32'd0;
        lcg_state = 32'h0b96f0a3;
        prog_len  = 0;
        alu_program_test();
        memory_program_test();
        branch_program_test();
        jump_program_test();
        timing_trap_test();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/rv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       prog_we,
    input  logic [rv_pkg::imem_aw-1:0] prog_addr,
    input  logic [rv_pkg::xlen-1:0]    prog_data,
    output logic                       retire,
    output logic [rv_pkg::xlen-1:0]    retire_pc,
    output logic                       wb_we,
    output logic [4:0]                 wb_rd,
    output logic [rv_pkg::xlen-1:0]    wb_data,
    output logic                       store_we,
    output logic [rv_pkg::xlen-1:0]    store_addr,
    output logic [rv_pkg::xlen-1:0]    store_data,
    output logic                       trap
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] ir;
    logic [xlen-1:0] a_reg;
    logic [xlen-1:0] b_reg;
    logic [xlen-1:0] imem_rdata;
    logic [xlen-1:0] dmem_rdata;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [3:0]      alu_flags;
    logic [xlen-1:0] pc_plus4_val;
    logic [xlen-1:0] br_target;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] rf_wdata;
    logic [xlen-1:0] fetch_addr;

    logic        ir_we;
    logic        pc_we;
    logic        rf_we;
    logic        d_mem_we;
    pc_src_e     pc_src;
    alu_a_sel_e  alu_a_sel;
    alu_b_sel_e  alu_b_sel;
    imm_sel_e    imm_sel;
    alu_cmd_e    alu_cmd;
    rf_src_e     rf_src;

    rv_control u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .opcode    (ir[6:0]),
        .funct3    (ir[14:12]),
        .funct7_5  (ir[30]),
        .alu_flags (alu_flags),
        .ir_we     (ir_we),
        .pc_we     (pc_we),
        .pc_src    (pc_src),
        .alu_a_sel (alu_a_sel),
        .alu_b_sel (alu_b_sel),
        .imm_sel   (imm_sel),
        .alu_cmd   (alu_cmd),
        .rf_src    (rf_src),
        .rf_we     (rf_we),
        .d_mem_we  (d_mem_we),
        .retire    (retire),
        .trap      (trap)
    );

    // pc and ir
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            pc <= '0;
        end else if (pc_we) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_we) begin
            ir <= imem_rdata;
        end
    end

    // operands latched every cycle, decode is the one that matters
    always_ff @(posedge clk) begin
        a_reg <= rs1_data;
        b_reg <= rs2_data;
    end

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (ir[19:15]),
        .rs2_addr (ir[24:20]),
        .rd_addr  (ir[11:7]),
        .rd_data  (rf_wdata),
        .we       (rf_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_imm_gen u_imm_gen (
        .instr   (ir),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    // alu operand muxes
    assign alu_a = (alu_a_sel == a_pc) ? pc : a_reg;
    assign alu_b = (alu_b_sel == b_imm) ? imm : b_reg;

    rv_alu u_alu (
        .a         (alu_a),
        .b         (alu_b),
        .alu_cmd   (alu_cmd),
        .result    (alu_result),
        .alu_flags (alu_flags)
    );

    // next pc
    assign pc_plus4_val = pc + 32'd4;
    assign br_target    = pc + imm;

    always_comb begin
        case (pc_src)
            pc_branch: pc_next = br_target;
            // jalr clears bit 0
            pc_jalr:   pc_next = {alu_result[xlen-1:1], 1'b0};
            default:   pc_next = pc_plus4_val;
        endcase
    end

    // write-back source
    always_comb begin
        case (rf_src)
            rf_mem:  rf_wdata = dmem_rdata;
            rf_pc4:  rf_wdata = pc_plus4_val;
            default: rf_wdata = alu_result;
        endcase
    end

    // read ahead at the next pc so the word is ready in fetch
    assign fetch_addr = pc_we ? pc_next : pc;

    // write port doubles as program load
    rv_memory u_imem (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (fetch_addr[imem_aw+1:2]),
        .rdata (imem_rdata)
    );

    // same alu address for store and load
    rv_memory u_dmem (
        .clk   (clk),
        .we    (d_mem_we),
        .waddr (alu_result[dmem_aw+1:2]),
        .wdata (b_reg),
        .raddr (alu_result[dmem_aw+1:2]),
        .rdata (dmem_rdata)
    );

    // observation ports
    assign retire_pc  = pc;
    assign wb_we      = rf_we;
    assign wb_rd      = ir[11:7];
    // x0 write shows as zero
    assign wb_data    = (ir[11:7] == 5'd0) ? '0 : rf_wdata;
    assign store_we   = d_mem_we;
    assign store_addr = alu_result;
    assign store_data = b_reg;

endmodule

`default_nettype wire

// File: verilog/rv_control.sv
`timescale 1ns/10ps
`default_nettype none

module rv_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    input  logic [6:0]           opcode,
    input  logic [2:0]           funct3,
    input  logic                 funct7_5,
    input  logic [3:0]           alu_flags,
    output logic                 ir_we,
    output logic                 pc_we,
    output rv_pkg::pc_src_e      pc_src,
    output rv_pkg::alu_a_sel_e   alu_a_sel,
    output rv_pkg::alu_b_sel_e   alu_b_sel,
    output rv_pkg::imm_sel_e     imm_sel,
    output rv_pkg::alu_cmd_e     alu_cmd,
    output rv_pkg::rf_src_e      rf_src,
    output logic                 rf_we,
    output logic                 d_mem_we,
    output logic                 retire,
    output logic                 trap
);
    import rv_pkg::*;

    state_e   state;
    alu_cmd_e r_cmd;
    logic     br_taken;

    // state register with active-high async reset
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state <= st_fetch;
        end else begin
            case (state)
                // hold in fetch until run goes high
                st_fetch: if (run) state <= st_decode;
                st_decode: begin
                    case (opcode)
                        op_rtype:  state <= st_exec_r;
                        op_load:   state <= st_exec_load;
                        op_imm:    state <= st_exec_imm;
                        op_store:  state <= st_exec_store;
                        op_branch: state <= st_exec_branch;
                        op_jalr:   state <= st_exec_jalr;
                        op_jal:    state <= st_exec_jal;
                        op_auipc:  state <= st_exec_auipc;
                        // unknown opcode
                        default:   state <= st_trap;
                    endcase
                end
                // load waits one more cycle for the dmem read
                st_exec_load: state <= st_mem_wb;
                // sticky until reset
                st_trap: state <= st_trap;
                default: state <= st_fetch;
            endcase
        end
    end

    // r-type alu command from funct3 / funct7 bit 5
    always_comb begin
        case (funct3)
            3'b000:  r_cmd = funct7_5 ? alu_sub : alu_add;
            3'b010:  r_cmd = alu_slt;
            3'b100:  r_cmd = alu_xor;
            3'b110:  r_cmd = alu_or;
            3'b111:  r_cmd = alu_and;
            default: r_cmd = alu_add;
        endcase
    end

    // beq on zero, bne on not zero
    assign br_taken = funct3[0] ? ~alu_flags[flag_zero] : alu_flags[flag_zero];

    // per-state selects with every enable low by default
    always_comb begin
        ir_we     = 1'b0;
        pc_we     = 1'b0;
        pc_src    = pc_plus4;
        alu_a_sel = a_rs1;
        alu_b_sel = b_rs2;
        imm_sel   = imm_i;
        alu_cmd   = alu_add;
        rf_src    = rf_alu;
        rf_we     = 1'b0;
        d_mem_we  = 1'b0;
        retire    = 1'b0;
        case (state)
            st_fetch: ir_we = run;
            st_exec_r: begin
                alu_cmd = r_cmd;
                rf_we   = 1'b1;
                pc_we   = 1'b1;
                retire  = 1'b1;
            end
            st_exec_imm: begin
                // addi only
                alu_b_sel = b_imm;
                rf_we     = 1'b1;
                pc_we     = 1'b1;
                retire    = 1'b1;
            end
            st_exec_load: begin
                // address only while the dmem read is in flight
                alu_b_sel = b_imm;
            end
            st_mem_wb: begin
                rf_src = rf_mem;
                rf_we  = 1'b1;
                pc_we  = 1'b1;
                retire = 1'b1;
            end
            st_exec_store: begin
                alu_b_sel = b_imm;
                imm_sel   = imm_s;
                d_mem_we  = 1'b1;
                pc_we     = 1'b1;
                retire    = 1'b1;
            end
            st_exec_branch: begin
                // compare via subtract
                alu_cmd = alu_sub;
                imm_sel = imm_b;
                pc_src  = br_taken ? pc_branch : pc_plus4;
                pc_we   = 1'b1;
                retire  = 1'b1;
            end
            st_exec_jal: begin
                // target comes from the pc adder
                imm_sel   = imm_j;
                rf_src    = rf_pc4;
                pc_src    = pc_branch;
                rf_we     = 1'b1;
                pc_we     = 1'b1;
                retire    = 1'b1;
            end
            st_exec_jalr: begin
                // target is rs1 + imm from the alu
                alu_b_sel = b_imm;
                rf_src    = rf_pc4;
                pc_src    = pc_jalr;
                rf_we     = 1'b1;
                pc_we     = 1'b1;
                retire    = 1'b1;
            end
            st_exec_auipc: begin
                alu_a_sel = a_pc;
                alu_b_sel = b_imm;
                imm_sel   = imm_u;
                rf_we     = 1'b1;
                pc_we     = 1'b1;
                retire    = 1'b1;
            end
            default: ;
        endcase
    end

    assign trap = (state == st_trap);

endmodule

`default_nettype wire

// File: verilog/rv_memory.sv
`timescale 1ns/10ps
`default_nettype none

module rv_memory (
    input  logic                       clk,
    input  logic                       we,
    input  logic [rv_pkg::imem_aw-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0]    wdata,
    input  logic [rv_pkg::imem_aw-1:0] raddr,
    output logic [rv_pkg::xlen-1:0]    rdata
);
    import rv_pkg::*;

    // word array, no reset
    logic [xlen-1:0] mem [imem_depth];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, one cycle latency
    // same-address write returns old data
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: verilog/rv_imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module rv_imm_gen (
    input  logic [rv_pkg::xlen-1:0] instr,
    input  rv_pkg::imm_sel_e        imm_sel,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    // sign bit is always instr[31]
    always_comb begin
        case (imm_sel)
            // loads, addi, jalr
            imm_i: imm = {{20{instr[31]}}, instr[31:20]};
            // stores, split field
            imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // branch offset, low bit zero
            imm_b: imm = {{19{instr[31]}}, instr[31], instr[7],
                          instr[30:25], instr[11:8], 1'b0};
            // jal offset, low bit zero
            imm_j: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                          instr[20], instr[30:21], 1'b0};
            // upper 20 bits
            imm_u: imm = {instr[31:12], 12'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    input  logic [4:0]              rd_addr,
    input  logic [rv_pkg::xlen-1:0] rd_data,
    input  logic                    we,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    // x0 cleared here and never written
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // async read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// File: verilog/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_cmd_e        alu_cmd,
    output logic [rv_pkg::xlen-1:0] result,
    output logic [3:0]              alu_flags
);
    import rv_pkg::*;

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic            ovf_add;
    logic            ovf_sub;

    assign sum  = a + b;
    assign diff = a - b;

    // same-sign operands, result sign flipped
    assign ovf_add = (a[xlen-1] == b[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    // opposite-sign operands for subtract
    assign ovf_sub = (a[xlen-1] != b[xlen-1]) && (diff[xlen-1] != a[xlen-1]);

    always_comb begin
        case (alu_cmd)
            alu_add: result = sum;
            alu_sub: result = diff;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            // signed less than
            alu_slt: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = sum;
        endcase
    end

    always_comb begin
        alu_flags            = 4'b0000;
        alu_flags[flag_zero] = (result == '0);
        alu_flags[flag_msb]  = result[xlen-1];
        // overflow only means something for add and sub
        case (alu_cmd)
            alu_add: alu_flags[flag_ovf] = ovf_add;
            alu_sub: alu_flags[flag_ovf] = ovf_sub;
            default: alu_flags[flag_ovf] = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // datapath width
    localparam int xlen = 32;

    // word memories, depth in words
    localparam int imem_depth = 256;
    localparam int imem_aw    = $clog2(imem_depth);
    localparam int dmem_depth = 256;
    localparam int dmem_aw    = $clog2(dmem_depth);

    // bit positions in the alu flag vector
    localparam int flag_zero = 0;
    localparam int flag_msb  = 1;
    localparam int flag_ovf  = 2;

    // rv32i major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_rtype  = 7'b0110011,
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111,
        op_auipc  = 7'b0010111
    } opcode_e;

    // control fsm states
    typedef enum logic [3:0] {
        st_fetch,
        st_decode,
        st_exec_r,
        st_exec_imm,
        st_exec_load,
        st_mem_wb,
        st_exec_store,
        st_exec_branch,
        st_exec_jal,
        st_exec_jalr,
        st_exec_auipc,
        st_trap
    } state_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_cmd_e;

    // datapath selects
    typedef enum logic {a_rs1, a_pc} alu_a_sel_e;
    typedef enum logic {b_rs2, b_imm} alu_b_sel_e;
    typedef enum logic [1:0] {rf_alu, rf_mem, rf_pc4} rf_src_e;
    typedef enum logic [1:0] {pc_plus4, pc_branch, pc_jalr} pc_src_e;
    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_j, imm_u} imm_sel_e;

endpackage

`default_nettype wire
